//--- hdl/iq_pkg.sv
`default_nettype none

package iq_pkg;

    parameter int max_latency = 4;
    parameter int num_ports = 3;
    parameter int num_bcast = 3;

    typedef logic [5:0] phys_reg_t;
    typedef logic [max_latency-1:0] lat_t;
    // ports 0, 1 and 2 are in use
    typedef logic [1:0] port_t;
    typedef logic [3:0] alu_op_t;
    typedef logic [4:0] rob_t;
    typedef logic [2:0] inst_type_t;
    typedef logic [2:0] imm_ptr_t;
    typedef logic [1:0] src_sel_t;

    // fields handed to the execute stage on issue
    typedef struct packed {
        phys_reg_t  src1;
        phys_reg_t  src2;
        phys_reg_t  dst;
        alu_op_t    alu_op;
        rob_t       rob_num;
        inst_type_t inst_type;
        imm_ptr_t   imm_ptr;
        src_sel_t   src_a_sel;
        src_sel_t   src_b_sel;
    } payload_t;

    typedef struct packed {
        payload_t payload;
        port_t    port;
        logic     uses_rs1;
        logic     uses_rs2;
        logic     ready1;
        logic     ready2;
        lat_t     delay1;
        lat_t     delay2;
    } dispatch_t;

    // result tag broadcast from one writeback source
    typedef struct packed {
        logic      en;
        phys_reg_t tag;
    } bcast_t;

endpackage

`default_nettype wire

//--- hdl/iq_select.sv
`timescale 1ns/1ps
`default_nettype none

module iq_select #(
    parameter int entries = 8,
    localparam int idx_w = $clog2(entries)
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [entries-1:0] req,
    output logic               grant,
    output logic [idx_w-1:0]   sel_idx
);

    logic [entries-1:0] req_q;
    logic               seen;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q <= '0;
        end else begin
            req_q <= req;
        end
    end

    assign grant = |req_q;

    // prefix scan, first set bit from index 0 wins
    always_comb begin
        seen = 1'b0;
        sel_idx = '0;
        for (int i = 0; i < entries; i++) begin
            if (req_q[i] && !seen) begin
                sel_idx = idx_w'(i);
            end
            seen = seen || req_q[i];
        end
    end

endmodule

`default_nettype wire

//--- hdl/iq_payload_ram.sv
`timescale 1ns/1ps
`default_nettype none

module iq_payload_ram #(
    parameter int entries = 8,
    localparam int idx_w = $clog2(entries)
) (
    input  logic             clk,
    input  logic             wr_en_1,
    input  logic             wr_en_2,
    input  logic [idx_w-1:0] wr_idx_1,
    input  logic [idx_w-1:0] wr_idx_2,
    input  iq_pkg::payload_t wr_data_1,
    input  iq_pkg::payload_t wr_data_2,
    input  logic [idx_w-1:0] rd_idx [iq_pkg::num_ports],
    output iq_pkg::payload_t rd_data [iq_pkg::num_ports]
);

    import iq_pkg::*;

    payload_t mem [entries];

    // slot 2 is written last so it wins on a shared entry
    always_ff @(posedge clk) begin
        if (wr_en_1) begin
            mem[wr_idx_1] <= wr_data_1;
        end
        if (wr_en_2) begin
            mem[wr_idx_2] <= wr_data_2;
        end
    end

    // read ports are asynchronous, one per issue port
    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            rd_data[p] = mem[rd_idx[p]];
        end
    end

endmodule

`default_nettype wire

//--- hdl/iq_wakeup.sv
`timescale 1ns/1ps
`default_nettype none

module iq_wakeup #(
    parameter int entries = 8,
    localparam int idx_w = $clog2(entries)
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               wr_en_1,
    input  logic               wr_en_2,
    input  logic [idx_w-1:0]   wr_idx_1,
    input  logic [idx_w-1:0]   wr_idx_2,
    input  iq_pkg::dispatch_t  disp_1,
    input  iq_pkg::dispatch_t  disp_2,
    input  iq_pkg::bcast_t     bcast [iq_pkg::num_bcast],
    output logic [entries-1:0] ready
);

    import iq_pkg::*;

    phys_reg_t          tag1 [entries];
    phys_reg_t          tag2 [entries];
    lat_t               delay1 [entries];
    lat_t               delay2 [entries];
    lat_t               shift1 [entries];
    lat_t               shift2 [entries];
    logic [entries-1:0] match1_q;
    logic [entries-1:0] match2_q;
    logic [entries-1:0] hit1;
    logic [entries-1:0] hit2;

    // a source needs no wakeup when unused or already available
    function automatic logic src_avail(input logic uses, input logic rdy);
        return !uses || rdy;
    endfunction

    // tag CAM against every enabled broadcast
    always_comb begin
        hit1 = '0;
        hit2 = '0;
        for (int i = 0; i < entries; i++) begin
            for (int b = 0; b < num_bcast; b++) begin
                if (bcast[b].en && (tag1[i] == bcast[b].tag)) begin
                    hit1[i] = 1'b1;
                end
                if (bcast[b].en && (tag2[i] == bcast[b].tag)) begin
                    hit2[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            match1_q <= '0;
            match2_q <= '0;
            for (int i = 0; i < entries; i++) begin
                shift1[i] <= '0;
                shift2[i] <= '0;
            end
        end else begin
            for (int i = 0; i < entries; i++) begin
                if (match1_q[i]) begin
                    shift1[i] <= {1'b1, shift1[i][max_latency-1:1]};
                end else if (hit1[i]) begin
                    shift1[i] <= delay1[i];
                    match1_q[i] <= 1'b1;
                end
                if (match2_q[i]) begin
                    shift2[i] <= {1'b1, shift2[i][max_latency-1:1]};
                end else if (hit2[i]) begin
                    shift2[i] <= delay2[i];
                    match2_q[i] <= 1'b1;
                end
            end
            // new allocation overrides any wakeup on the same entry
            if (wr_en_1) begin
                match1_q[wr_idx_1] <= src_avail(disp_1.uses_rs1, disp_1.ready1);
                match2_q[wr_idx_1] <= src_avail(disp_1.uses_rs2, disp_1.ready2);
                shift1[wr_idx_1] <= {max_latency{src_avail(disp_1.uses_rs1, disp_1.ready1)}};
                shift2[wr_idx_1] <= {max_latency{src_avail(disp_1.uses_rs2, disp_1.ready2)}};
            end
            if (wr_en_2) begin
                match1_q[wr_idx_2] <= src_avail(disp_2.uses_rs1, disp_2.ready1);
                match2_q[wr_idx_2] <= src_avail(disp_2.uses_rs2, disp_2.ready2);
                shift1[wr_idx_2] <= {max_latency{src_avail(disp_2.uses_rs1, disp_2.ready1)}};
                shift2[wr_idx_2] <= {max_latency{src_avail(disp_2.uses_rs2, disp_2.ready2)}};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_1) begin
            tag1[wr_idx_1] <= disp_1.payload.src1;
            tag2[wr_idx_1] <= disp_1.payload.src2;
            delay1[wr_idx_1] <= disp_1.delay1;
            delay2[wr_idx_1] <= disp_1.delay2;
        end
        if (wr_en_2) begin
            tag1[wr_idx_2] <= disp_2.payload.src1;
            tag2[wr_idx_2] <= disp_2.payload.src2;
            delay1[wr_idx_2] <= disp_2.delay1;
            delay2[wr_idx_2] <= disp_2.delay2;
        end
    end

    always_comb begin
        for (int i = 0; i < entries; i++) begin
            ready[i] = shift1[i][0] && shift2[i][0];
        end
    end

endmodule

`default_nettype wire

//--- hdl/iq_entry_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module iq_entry_ctrl #(
    parameter int entries = 8,
    localparam int idx_w = $clog2(entries)
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               wr_en_1,
    input  logic               wr_en_2,
    input  logic [idx_w-1:0]   wr_idx_1,
    input  logic [idx_w-1:0]   wr_idx_2,
    input  iq_pkg::port_t      wr_port_1,
    input  iq_pkg::port_t      wr_port_2,
    input  logic [entries-1:0] ready,
    input  logic               grant [iq_pkg::num_ports],
    input  logic [idx_w-1:0]   sel_idx [iq_pkg::num_ports],
    output logic [entries-1:0] req [iq_pkg::num_ports]
);

    import iq_pkg::*;

    logic [entries-1:0] valid_q;
    port_t              port_q [entries];
    logic [entries-1:0] alloc_mask;
    logic [entries-1:0] issued;

    always_comb begin
        alloc_mask = '0;
        if (wr_en_1) begin
            alloc_mask[wr_idx_1] = 1'b1;
        end
        if (wr_en_2) begin
            alloc_mask[wr_idx_2] = 1'b1;
        end
    end

    // entries handed out by a selector in this cycle
    always_comb begin
        issued = '0;
        for (int p = 0; p < num_ports; p++) begin
            if (grant[p]) begin
                issued[sel_idx[p]] = 1'b1;
            end
        end
    end

    // an issued entry must not reach the selector again
    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            for (int i = 0; i < entries; i++) begin
                req[p][i] = valid_q[i] && ready[i] && !issued[i]
                            && (port_q[i] == port_t'(p));
            end
        end
    end

    // allocation beats release on the same entry
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= (valid_q & ~issued) | alloc_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_1) begin
            port_q[wr_idx_1] <= wr_port_1;
        end
        if (wr_en_2) begin
            port_q[wr_idx_2] <= wr_port_2;
        end
    end

endmodule

`default_nettype wire

//--- hdl/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue #(
    parameter int entries = 8,
    localparam int idx_w = $clog2(entries)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              alloc_valid_1,
    input  logic              alloc_valid_2,
    input  logic              stall_dp,
    input  logic [idx_w-1:0]  alloc_idx_1,
    input  logic [idx_w-1:0]  alloc_idx_2,
    input  iq_pkg::dispatch_t disp_1,
    input  iq_pkg::dispatch_t disp_2,
    input  iq_pkg::bcast_t    bcast [iq_pkg::num_bcast],
    output logic              grant [iq_pkg::num_ports],
    output iq_pkg::payload_t  issue [iq_pkg::num_ports]
);

    import iq_pkg::*;

    logic               wr_en_1;
    logic               wr_en_2;
    logic [entries-1:0] ready;
    logic [entries-1:0] req [num_ports];
    logic [idx_w-1:0]   sel_idx [num_ports];

    // the dispatch stall is only looked at here
    assign wr_en_1 = alloc_valid_1 && !stall_dp;
    assign wr_en_2 = alloc_valid_2 && !stall_dp;

    iq_entry_ctrl #(
        .entries(entries)
    ) u_entry_ctrl (
        .clk       (clk),
        .reset     (reset),
        .wr_en_1   (wr_en_1),
        .wr_en_2   (wr_en_2),
        .wr_idx_1  (alloc_idx_1),
        .wr_idx_2  (alloc_idx_2),
        .wr_port_1 (disp_1.port),
        .wr_port_2 (disp_2.port),
        .ready     (ready),
        .grant     (grant),
        .sel_idx   (sel_idx),
        .req       (req)
    );

    iq_wakeup #(
        .entries(entries)
    ) u_wakeup (
        .clk      (clk),
        .reset    (reset),
        .wr_en_1  (wr_en_1),
        .wr_en_2  (wr_en_2),
        .wr_idx_1 (alloc_idx_1),
        .wr_idx_2 (alloc_idx_2),
        .disp_1   (disp_1),
        .disp_2   (disp_2),
        .bcast    (bcast),
        .ready    (ready)
    );

    iq_payload_ram #(
        .entries(entries)
    ) u_payload_ram (
        .clk       (clk),
        .wr_en_1   (wr_en_1),
        .wr_en_2   (wr_en_2),
        .wr_idx_1  (alloc_idx_1),
        .wr_idx_2  (alloc_idx_2),
        .wr_data_1 (disp_1.payload),
        .wr_data_2 (disp_2.payload),
        .rd_idx    (sel_idx),
        .rd_data   (issue)
    );

    // one selector per issue port
    for (genvar p = 0; p < num_ports; p++) begin : g_sel
        iq_select #(
            .entries(entries)
        ) u_select (
            .clk     (clk),
            .reset   (reset),
            .req     (req[p]),
            .grant   (grant[p]),
            .sel_idx (sel_idx[p])
        );
    end

endmodule

`default_nettype wire

//--- tb/issue_queue_sva.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue_sva #(
    parameter int entries = 8,
    localparam int idx_w = $clog2(entries)
) (
    input logic             clk,
    input logic             reset,
    input logic             wr_en_1,
    input logic             wr_en_2,
    input logic [idx_w-1:0] alloc_idx_1,
    input logic [idx_w-1:0] alloc_idx_2,
    input logic             grant [iq_pkg::num_ports],
    input logic [idx_w-1:0] sel_idx [iq_pkg::num_ports]
);

    import iq_pkg::*;

    logic [entries-1:0] granted;
    logic [entries-1:0] alloc;
    logic [entries-1:0] live_q;

    always_comb begin
        granted = '0;
        alloc = '0;
        for (int p = 0; p < num_ports; p++) begin
            if (grant[p]) begin
                granted[sel_idx[p]] = 1'b1;
            end
        end
        if (wr_en_1) begin
            alloc[alloc_idx_1] = 1'b1;
        end
        if (wr_en_2) begin
            alloc[alloc_idx_2] = 1'b1;
        end
    end

    // entries allocated and not yet issued
    always_ff @(posedge clk) begin
        if (reset) begin
            live_q <= '0;
        end else begin
            live_q <= (live_q & ~granted) | alloc;
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk) reset |=> (granted == '0))
        else $error("grant raised during or right after reset");

    for (genvar p = 0; p < num_ports; p++) begin : g_port
        a_idx_range: assert property (@(posedge clk) disable iff (reset)
            grant[p] |-> ((32'(sel_idx[p]) < entries) && live_q[sel_idx[p]]))
            else $error("selected index names no live entry on port %0d", p);
        for (genvar q = p + 1; q < num_ports; q++) begin : g_pair
            a_distinct: assert property (@(posedge clk) disable iff (reset)
                (grant[p] && grant[q]) |-> (sel_idx[p] != sel_idx[q]))
                else $error("entry granted on ports %0d and %0d together", p, q);
        end
    end

    // reallocation at the release edge makes a new instruction
    a_no_repeat: assert property (@(posedge clk) disable iff (reset)
        (granted != '0) |=> ((granted & $past(granted & ~alloc)) == '0))
        else $error("entry granted on consecutive cycles");

endmodule

bind issue_queue issue_queue_sva #(
    .entries(entries)
) u_sva (
    .clk         (clk),
    .reset       (reset),
    .wr_en_1     (wr_en_1),
    .wr_en_2     (wr_en_2),
    .alloc_idx_1 (alloc_idx_1),
    .alloc_idx_2 (alloc_idx_2),
    .grant       (grant),
    .sel_idx     (sel_idx)
);

`default_nettype wire

//--- tb/tb_issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_issue_queue;

    import iq_pkg::*;

    localparam int entries = 8;
    localparam int idx_w = $clog2(entries);
    localparam int num_rows = 12;
    localparam int drain_limit = 40;

    typedef logic [idx_w-1:0] idx_t;

    // one dispatch slot of a table row
    typedef struct packed {
        logic      v;
        idx_t      idx;
        port_t     port;
        logic      u1;
        logic      r1;
        phys_reg_t t1;
        lat_t      d1;
        logic      u2;
        logic      r2;
        phys_reg_t t2;
        lat_t      d2;
    } slot_t;

    // gap is the number of idle cycles before the row is applied
    typedef struct packed {
        logic [3:0] gap;
        slot_t      s1;
        slot_t      s2;
        bcast_t     b0;
        bcast_t     b1;
        bcast_t     b2;
        logic       stall;
    } row_t;

    logic      clk;
    logic      reset;
    logic      alloc_valid_1;
    logic      alloc_valid_2;
    logic      stall_dp;
    idx_t      alloc_idx_1;
    idx_t      alloc_idx_2;
    dispatch_t disp_1;
    dispatch_t disp_2;
    bcast_t    bcast [num_bcast];
    logic      grant [num_ports];
    payload_t  issue [num_ports];

    row_t        rows [num_rows];
    logic [31:0] seed;
    int          grant_errors;
    int          issue_errors;
    int          other_errors;
    int          grants_seen;
    int          expected_issues;

    // reference model state
    logic               m_valid [entries];
    port_t              m_port [entries];
    payload_t           m_pay [entries];
    phys_reg_t          m_tag [entries][2];
    int                 m_dly [entries][2];
    logic               m_wait [entries][2];
    int                 m_cnt [entries][2];
    logic [entries-1:0] m_req_q [num_ports];

    issue_queue #(
        .entries(entries)
    ) DUT (
        .clk           (clk),
        .reset         (reset),
        .alloc_valid_1 (alloc_valid_1),
        .alloc_valid_2 (alloc_valid_2),
        .stall_dp      (stall_dp),
        .alloc_idx_1   (alloc_idx_1),
        .alloc_idx_2   (alloc_idx_2),
        .disp_1        (disp_1),
        .disp_2        (disp_2),
        .bcast         (bcast),
        .grant         (grant),
        .issue         (issue)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic idx_t lowest_set(input logic [entries-1:0] v);
        idx_t r;
        r = '0;
        for (int i = entries - 1; i >= 0; i--) begin
            if (v[i]) begin
                r = idx_t'(i);
            end
        end
        return r;
    endfunction

    // edges from the broadcast until the source reads ready
    function automatic int wake_edges(input lat_t d);
        int r;
        r = max_latency;
        for (int k = max_latency - 1; k >= 0; k--) begin
            if (d[k]) begin
                r = k;
            end
        end
        return r;
    endfunction

    function automatic logic src_ready(input int i, input int s);
        return !m_wait[i][s] && (m_cnt[i][s] == 0);
    endfunction

    function automatic logic busy();
        logic b;
        b = 1'b0;
        for (int i = 0; i < entries; i++) begin
            b = b || m_valid[i];
        end
        for (int p = 0; p < num_ports; p++) begin
            b = b || (|m_req_q[p]);
        end
        return b;
    endfunction

    function automatic slot_t dispatch_slot(input idx_t idx, input port_t port,
                                            input logic u1, input logic r1,
                                            input phys_reg_t t1, input lat_t d1,
                                            input logic u2, input logic r2,
                                            input phys_reg_t t2, input lat_t d2);
        slot_t s;
        s = '{v: 1'b1, idx: idx, port: port, u1: u1, r1: r1, t1: t1, d1: d1,
              u2: u2, r2: r2, t2: t2, d2: d2};
        return s;
    endfunction

    function automatic bcast_t tag_pulse(input logic en, input phys_reg_t tag);
        bcast_t b;
        b.en = en;
        b.tag = tag;
        return b;
    endfunction

    function automatic row_t table_row(input int gap, input slot_t s1, input slot_t s2,
                                       input bcast_t b0, input bcast_t b1, input bcast_t b2,
                                       input logic stall);
        row_t r;
        r = '{gap: 4'(gap), s1: s1, s2: s2, b0: b0, b1: b1, b2: b2, stall: stall};
        return r;
    endfunction

    task automatic load_table();
        slot_t  none;
        bcast_t off;
        none = '0;
        off = '0;
        // quiet queue after reset
        rows[0] = table_row(6, none, none, off, off, off, 1'b0);
        // dual dispatch, second slot without sources
        rows[1] = table_row(0,
            dispatch_slot(3'd0, 2'd0, 1'b1, 1'b1, 6'h01, 4'hf, 1'b1, 1'b1, 6'h02, 4'hf),
            dispatch_slot(3'd1, 2'd1, 1'b0, 1'b0, 6'h03, 4'hf, 1'b0, 1'b0, 6'h04, 4'hf),
            off, off, off, 1'b0);
        // waiting sources, then a disabled and two enabled broadcasts
        rows[2] = table_row(4,
            dispatch_slot(3'd2, 2'd2, 1'b1, 1'b0, 6'h11, 4'b1100, 1'b0, 1'b0, 6'h00, 4'h0),
            dispatch_slot(3'd3, 2'd0, 1'b1, 1'b0, 6'h05, 4'b1111, 1'b1, 1'b0, 6'h06, 4'b1110),
            off, off, off, 1'b0);
        rows[3] = table_row(2, none, none, tag_pulse(1'b0, 6'h11), off, off, 1'b0);
        rows[4] = table_row(2, none, none, tag_pulse(1'b1, 6'h05), tag_pulse(1'b1, 6'h11),
                            tag_pulse(1'b0, 6'h06), 1'b0);
        rows[5] = table_row(3, none, none, off, off, tag_pulse(1'b1, 6'h06), 1'b0);
        // one port crowded, others in parallel
        rows[6] = table_row(6,
            dispatch_slot(3'd4, 2'd1, 1'b1, 1'b1, 6'h21, 4'hf, 1'b1, 1'b1, 6'h22, 4'hf),
            dispatch_slot(3'd6, 2'd1, 1'b1, 1'b1, 6'h23, 4'hf, 1'b0, 1'b0, 6'h24, 4'hf),
            off, off, off, 1'b0);
        rows[7] = table_row(0,
            dispatch_slot(3'd5, 2'd1, 1'b1, 1'b1, 6'h25, 4'hf, 1'b1, 1'b1, 6'h26, 4'hf),
            dispatch_slot(3'd7, 2'd0, 1'b1, 1'b1, 6'h27, 4'hf, 1'b1, 1'b1, 6'h28, 4'hf),
            off, off, off, 1'b0);
        rows[8] = table_row(0,
            dispatch_slot(3'd0, 2'd2, 1'b1, 1'b1, 6'h29, 4'hf, 1'b1, 1'b1, 6'h2a, 4'hf),
            dispatch_slot(3'd1, 2'd0, 1'b1, 1'b1, 6'h2b, 4'hf, 1'b1, 1'b1, 6'h2c, 4'hf),
            off, off, off, 1'b0);
        // stalled dispatch is dropped
        rows[9] = table_row(6,
            dispatch_slot(3'd2, 2'd0, 1'b1, 1'b1, 6'h31, 4'hf, 1'b1, 1'b1, 6'h32, 4'hf),
            dispatch_slot(3'd3, 2'd1, 1'b1, 1'b1, 6'h33, 4'hf, 1'b1, 1'b1, 6'h34, 4'hf),
            off, off, off, 1'b1);
        // second row lands on the edge that releases entry 2
        rows[10] = table_row(4,
            dispatch_slot(3'd2, 2'd2, 1'b1, 1'b1, 6'h35, 4'hf, 1'b1, 1'b1, 6'h36, 4'hf),
            none, off, off, off, 1'b0);
        rows[11] = table_row(1,
            dispatch_slot(3'd2, 2'd1, 1'b1, 1'b1, 6'h37, 4'hf, 1'b1, 1'b1, 6'h38, 4'hf),
            none, off, off, off, 1'b0);
    endtask

    task automatic fill_dispatch(input slot_t s, output dispatch_t d);
        logic [63:0] bits;
        seed = xorshift(seed);
        bits[63:32] = seed;
        seed = xorshift(seed);
        bits[31:0] = seed;
        d.payload = payload_t'(bits[$bits(payload_t)-1:0]);
        d.payload.src1 = s.t1;
        d.payload.src2 = s.t2;
        d.port = s.port;
        d.uses_rs1 = s.u1;
        d.uses_rs2 = s.u2;
        d.ready1 = s.r1;
        d.ready2 = s.r2;
        d.delay1 = s.d1;
        d.delay2 = s.d2;
    endtask

    task automatic drive(input row_t r);
        dispatch_t d1;
        dispatch_t d2;
        fill_dispatch(r.s1, d1);
        fill_dispatch(r.s2, d2);
        alloc_valid_1 <= r.s1.v;
        alloc_valid_2 <= r.s2.v;
        alloc_idx_1 <= r.s1.idx;
        alloc_idx_2 <= r.s2.idx;
        disp_1 <= d1;
        disp_2 <= d2;
        bcast[0] <= r.b0;
        bcast[1] <= r.b1;
        bcast[2] <= r.b2;
        stall_dp <= r.stall;
    endtask

    task automatic allocate(input idx_t i, input dispatch_t d);
        m_valid[i] = 1'b1;
        m_port[i] = d.port;
        m_pay[i] = d.payload;
        m_tag[i][0] = d.payload.src1;
        m_tag[i][1] = d.payload.src2;
        m_dly[i][0] = wake_edges(d.delay1);
        m_dly[i][1] = wake_edges(d.delay2);
        m_wait[i][0] = d.uses_rs1 && !d.ready1;
        m_wait[i][1] = d.uses_rs2 && !d.ready2;
        m_cnt[i][0] = 0;
        m_cnt[i][1] = 0;
    endtask

    // advance the model by one edge using the inputs now on the DUT
    task automatic model_step();
        logic [entries-1:0] released;
        logic [entries-1:0] nreq [num_ports];
        logic               hit;
        released = '0;
        for (int p = 0; p < num_ports; p++) begin
            if (|m_req_q[p]) begin
                released[lowest_set(m_req_q[p])] = 1'b1;
            end
        end
        for (int p = 0; p < num_ports; p++) begin
            for (int i = 0; i < entries; i++) begin
                nreq[p][i] = m_valid[i] && src_ready(i, 0) && src_ready(i, 1)
                             && !released[i] && (m_port[i] == port_t'(p));
            end
        end
        if (reset) begin
            for (int i = 0; i < entries; i++) begin
                m_valid[i] = 1'b0;
                m_wait[i][0] = 1'b1;
                m_wait[i][1] = 1'b1;
                m_cnt[i][0] = 0;
                m_cnt[i][1] = 0;
            end
            for (int p = 0; p < num_ports; p++) begin
                m_req_q[p] = '0;
            end
        end else begin
            for (int p = 0; p < num_ports; p++) begin
                m_req_q[p] = nreq[p];
            end
            for (int i = 0; i < entries; i++) begin
                if (released[i]) begin
                    m_valid[i] = 1'b0;
                end
                for (int s = 0; s < 2; s++) begin
                    hit = 1'b0;
                    for (int b = 0; b < num_bcast; b++) begin
                        if (bcast[b].en && (bcast[b].tag == m_tag[i][s])) begin
                            hit = 1'b1;
                        end
                    end
                    if (m_wait[i][s] && hit) begin
                        m_wait[i][s] = 1'b0;
                        m_cnt[i][s] = m_dly[i][s];
                    end else if (!m_wait[i][s] && m_cnt[i][s] > 0) begin
                        m_cnt[i][s] = m_cnt[i][s] - 1;
                    end
                end
            end
            // slot 2 goes last and wins a shared entry
            if (alloc_valid_1 && !stall_dp) begin
                allocate(alloc_idx_1, disp_1);
            end
            if (alloc_valid_2 && !stall_dp) begin
                allocate(alloc_idx_2, disp_2);
            end
        end
    endtask

    task automatic check_outputs();
        logic     exp_grant;
        payload_t exp_issue;
        for (int p = 0; p < num_ports; p++) begin
            exp_grant = |m_req_q[p];
            exp_issue = m_pay[lowest_set(m_req_q[p])];
            if (grant[p] === 1'b1) begin
                grants_seen++;
            end
            assert (grant[p] === exp_grant) else begin
                grant_errors++;
                $display("mismatch grant[%0d] at %0t: got %h expected %h",
                         p, $time, grant[p], exp_grant);
            end
            if (exp_grant) begin
                assert (issue[p] === exp_issue) else begin
                    issue_errors++;
                    $display("mismatch issue[%0d] at %0t: got %h expected %h",
                             p, $time, issue[p], exp_issue);
                end
            end
        end
    endtask

    task automatic cycle(input row_t r, input logic rst);
        @(posedge clk);
        reset <= rst;
        drive(r);
        @(negedge clk);
        check_outputs();
        model_step();
    endtask

    initial begin
        int waited;
        clk = 1'b0;
        reset = 1'b1;
        alloc_valid_1 = 1'b0;
        alloc_valid_2 = 1'b0;
        stall_dp = 1'b0;
        alloc_idx_1 = '0;
        alloc_idx_2 = '0;
        disp_1 = '0;
        disp_2 = '0;
        for (int b = 0; b < num_bcast; b++) begin
            bcast[b] = '0;
        end
        seed = 32'h94da;
        grant_errors = 0;
        issue_errors = 0;
        other_errors = 0;
        grants_seen = 0;
        for (int p = 0; p < num_ports; p++) begin
            m_req_q[p] = '0;
        end
        for (int i = 0; i < entries; i++) begin
            m_valid[i] = 1'b0;
        end
        load_table();
        expected_issues = 0;
        for (int n = 0; n < num_rows; n++) begin
            if (!rows[n].stall) begin
                expected_issues += int'(rows[n].s1.v) + int'(rows[n].s2.v);
            end
        end

        // the initial value covers the first of four reset edges
        for (int c = 0; c < 3; c++) begin
            cycle('0, 1'b1);
        end
        for (int n = 0; n < num_rows; n++) begin
            for (int g = 0; g < int'(rows[n].gap); g++) begin
                cycle('0, 1'b0);
            end
            cycle(rows[n], 1'b0);
        end

        waited = 0;
        while (busy() && waited < drain_limit) begin
            cycle('0, 1'b0);
            waited++;
        end
        if (busy()) begin
            other_errors++;
            $display("timeout: queue still holds entries after %0d idle cycles", drain_limit);
        end
        cycle('0, 1'b0);
        assert (grants_seen == expected_issues) else begin
            other_errors++;
            $display("mismatch grant count: got %h expected %h", grants_seen, expected_issues);
        end

        $display("errors: grant %0d, issue %0d, other %0d",
                 grant_errors, issue_errors, other_errors);
        if (grant_errors + issue_errors + other_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hdl/iq_pkg.sv
hdl/iq_select.sv
hdl/iq_payload_ram.sv
hdl/iq_wakeup.sv
hdl/iq_entry_ctrl.sv
hdl/issue_queue.sv
tb/issue_queue_sva.sv
tb/tb_issue_queue.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_issue_queue
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := tests failed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
